// ==== source/physics_pkg.sv ====
`default_nettype none

package physics_pkg;

	// Fixed point 16.32, signed
	localparam int INT_BITS  = 16;
	localparam int FRAC_BITS = 32;
	localparam int FIX_W     = INT_BITS + FRAC_BITS;

	typedef logic signed [FIX_W-1:0] fix_t;

	// Register bus widths
	localparam int DATA_W     = 32;
	localparam int AXI_ADDR_W = 4;

	// Pixel pair, x high and y low
	typedef struct packed {
		logic signed [INT_BITS-1:0] x;
		logic signed [INT_BITS-1:0] y;
	} coord_xy_t;

	// Same word seen by the bus and by the physics
	typedef union packed {
		logic [DATA_W-1:0] raw;
		coord_xy_t         xy;
	} coord_pair_u;

	// Joystick mapping
	localparam int JOY_CENTER = 112; // Raw byte bias
	localparam int JOY_SCALE  = 256; // Move step per joystick count
	localparam int JUMP_MIN   = 240; // Stick pushed up

	localparam int ARENA_W = 640;
	localparam int ARENA_H = 480;

	// Attack vibration, in fraction units
	localparam fix_t VIBR_SPAN = 48'sd10000000;
	localparam fix_t VIBR_STEP = 48'sd2;
	localparam fix_t LIFT      = fix_t'(1) << FRAC_BITS; // One pixel up

	// Unit divisor, also the floor for a zero mass write
	localparam logic [DATA_W-1:0] MASS_ONE = 32'd1;

	// Register map
	localparam logic [AXI_ADDR_W-1:0] REG_MASS     = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_GRAVITY  = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_SPAWN    = 4'h8;
	localparam logic [AXI_ADDR_W-1:0] REG_POSITION = 4'hC; // Read only

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

endpackage

`default_nettype wire

// ==== source/physics_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

// Host configuration into the integrator
interface body_config_if import physics_pkg::*; ();
	fix_t        mass;
	fix_t        gravity;
	coord_pair_u spawn;
	logic        respawn; // One cycle after a spawn write

	modport source (output mass, gravity, spawn, respawn);
	modport sink   (input mass, gravity, spawn, respawn);
endinterface

// Decoded frame command
interface motion_cmd_if import physics_pkg::*; ();
	logic cmd_valid;
	fix_t move_x, move_y;
	fix_t knock_x, knock_y;
	logic grounded, jump, attack, freeze;

	modport source (output cmd_valid, move_x, move_y, knock_x, knock_y,
		grounded, jump, attack, freeze);
	modport sink   (input cmd_valid, move_x, move_y, knock_x, knock_y,
		grounded, jump, attack, freeze);
endinterface

// Integrated body position
interface body_state_if import physics_pkg::*; ();
	logic state_valid;
	fix_t pos_x, pos_y;

	modport source (output state_valid, pos_x, pos_y);
	modport sink   (input state_valid, pos_x, pos_y);
endinterface

`default_nettype wire

// ==== source/physics_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module physics_regs import physics_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire  [AXI_ADDR_W-1:0] awaddr,
	input  wire                   awvalid,
	output logic                  awready,
	input  wire  [DATA_W-1:0]     wdata,
	input  wire                   wvalid,
	output logic                  wready,
	output resp_t                 bresp,
	output logic                  bvalid,
	input  wire                   bready,
	input  wire  [AXI_ADDR_W-1:0] araddr,
	input  wire                   arvalid,
	output logic                  arready,
	output logic [DATA_W-1:0]     rdata,
	output resp_t                 rresp,
	output logic                  rvalid,
	input  wire                   rready,
	input  wire  coord_pair_u     position_now,
	body_config_if.source         cfg
);

	logic              wr_ready; // Shared by AW and W
	logic              wr_fire;
	logic              rd_fire;
	logic [DATA_W-1:0] mass_q;
	logic [DATA_W-1:0] gravity_q;
	coord_pair_u       spawn_q;
	logic              respawn_q;

	assign awready = wr_ready;
	assign wready  = wr_ready;
	assign wr_fire = wr_ready & awvalid & wvalid;
	assign rd_fire = arready & arvalid;

	// Both are zero extended into the fraction bits
	assign cfg.mass    = fix_t'(mass_q);
	assign cfg.gravity = fix_t'(gravity_q);
	assign cfg.spawn   = spawn_q;
	assign cfg.respawn = respawn_q;

	// Write channel and config registers
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ready    <= 1'b0;
			bvalid      <= 1'b0;
			mass_q      <= MASS_ONE;
			gravity_q   <= '0;
			spawn_q.raw <= '0;
			respawn_q   <= 1'b0;
		end else begin
			// Ready for one cycle while no response waits
			wr_ready  <= awvalid & wvalid & ~wr_ready & ~bvalid;
			respawn_q <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					REG_MASS:    mass_q <= (wdata == '0) ? MASS_ONE : wdata; // Keep divide defined
					REG_GRAVITY: gravity_q <= wdata;
					REG_SPAWN: begin
						spawn_q.raw <= wdata;
						respawn_q   <= 1'b1; // Integrator reloads next cycle
					end
					default: ;                 // Position and holes ignore writes
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wr_fire)
			bresp <= (awaddr inside {REG_MASS, REG_GRAVITY, REG_SPAWN}) ? OKAY : SLVERR;
	end

	// Read channel
	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid & ~arready & ~rvalid;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			rresp <= OKAY;
			case (araddr)
				REG_MASS:     rdata <= mass_q;
				REG_GRAVITY:  rdata <= gravity_q;
				REG_SPAWN:    rdata <= spawn_q.raw;
				REG_POSITION: rdata <= position_now.raw; // Live clamped pixels
				default: begin
					rdata <= '0;
					rresp <= SLVERR;
				end
			endcase
		end
	end

	// Response and its code wait for the master
	assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

// ==== source/input_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module input_decode import physics_pkg::*; (
	input  wire               clock,
	input  wire               reset,
	input  wire               step,
	input  wire  [31:0]       controller,
	input  wire  [4:0]        wall,
	input  wire  coord_pair_u knockback,
	input  wire               attack_in,
	input  wire               freeze_in,
	motion_cmd_if.source      cmd
);

	logic [7:0] joy_x;
	logic [7:0] joy_y;
	fix_t       move_x_next;
	fix_t       move_y_next;
	logic       on_ground;

	assign joy_x = controller[15:8];
	assign joy_y = controller[7:0];

	// Unsigned stick byte to signed move
	assign move_x_next = fix_t'((int'(joy_x) - JOY_CENTER) * JOY_SCALE);
	assign move_y_next = fix_t'((int'(joy_y) - JOY_CENTER) * JOY_SCALE);

	// Floor bit 1 or platform bit 4
	// Side and ceiling bits carry no response
	assign on_ground = wall[1] | wall[4];

	always_ff @(posedge clock) begin
		if (reset)
			cmd.cmd_valid <= 1'b0;
		else
			cmd.cmd_valid <= step; // One frame command per step
	end

	// Command word, captured on step only
	always_ff @(posedge clock) begin
		if (step) begin
			cmd.move_x   <= move_x_next;
			cmd.move_y   <= move_y_next;
			cmd.knock_x  <= fix_t'(knockback.xy.x); // Sign extended
			cmd.knock_y  <= fix_t'(knockback.xy.y);
			cmd.grounded <= on_ground;
			cmd.jump     <= (int'(joy_y) >= JUMP_MIN);
			cmd.attack   <= attack_in;
			cmd.freeze   <= freeze_in;
		end
	end

	// Host holds off frames during reset
	assert property (@(posedge clock) reset |-> !step);

endmodule

`default_nettype wire

// ==== source/motion_integrator.sv ====
`timescale 1ns/1ns
`default_nettype none

module motion_integrator import physics_pkg::*; (
	input  wire           clock,
	input  wire           reset,
	body_config_if.sink   cfg,
	motion_cmd_if.sink    cmd,
	body_state_if.source  state
);

	fix_t vel_x;
	fix_t vel_y;
	fix_t pos_x;
	fix_t pos_y;
	fix_t vibr_ref;    // Height where vibration started
	logic attack_prev;
	logic valid_q;
	fix_t walk_vx;
	fix_t walk_vy;
	fix_t knock_vx;
	fix_t knock_vy;
	logic step_live;
	logic attack_start;
	logic vibr_up;

	// Integer divide, mass never zero
	assign walk_vx  = cmd.move_x / cfg.mass;
	assign walk_vy  = cmd.move_y / cfg.mass;
	assign knock_vx = cmd.knock_x / cfg.mass;
	assign knock_vy = cmd.knock_y / cfg.mass;

	// Frame that actually moves the body
	assign step_live    = cmd.cmd_valid & ~cmd.freeze & ~cfg.respawn;
	assign attack_start = step_live & cmd.attack & ~attack_prev;

	assign vibr_up = (pos_y < vibr_ref + VIBR_SPAN);

	assign state.state_valid = valid_q;
	assign state.pos_x       = pos_x;
	assign state.pos_y       = pos_y;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q     <= 1'b0;
			attack_prev <= 1'b0;
			vel_x       <= '0;
			vel_y       <= '0;
			pos_x       <= '0;
			pos_y       <= '0;
		end else begin
			valid_q <= cmd.cmd_valid; // Frozen frames still report
			if (cfg.respawn) begin
				// Spawn pixels into integer bits, body at rest
				pos_x       <= {cfg.spawn.xy.x, {FRAC_BITS{1'b0}}};
				pos_y       <= {cfg.spawn.xy.y, {FRAC_BITS{1'b0}}};
				vel_x       <= '0;
				vel_y       <= '0;
				attack_prev <= 1'b0;
			end else if (step_live) begin
				attack_prev <= cmd.attack;
				if (attack_start) begin
					pos_y <= pos_y + LIFT;  // Off the ground
				end else if (cmd.attack) begin
					vel_x <= knock_vx;      // Knockback held for release
					vel_y <= knock_vy;
					if (vibr_up)
						pos_y <= pos_y + VIBR_STEP;
					else
						pos_y <= pos_y - VIBR_STEP;
				end else begin
					vel_x <= walk_vx;
					if (cmd.jump)
						vel_y <= walk_vy;  // No gravity on the jump frame
					else if (cmd.grounded)
						vel_y <= '0;
					else
						vel_y <= walk_vy - cfg.gravity;
					// Position trails velocity by a frame
					pos_x <= pos_x + vel_x;
					if (!cmd.grounded)
						pos_y <= pos_y + vel_y;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (attack_start)
			vibr_ref <= pos_y + LIFT;
	end

	// Register block floors mass before any frame uses it
	assert property (@(posedge clock) disable iff (reset) cmd.cmd_valid |-> cfg.mass != '0);

endmodule

`default_nettype wire

// ==== source/position_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module position_result import physics_pkg::*; (
	input  wire               clock,
	input  wire               reset,
	body_state_if.sink        state,
	output coord_pair_u       position,
	output logic              position_valid
);

	logic signed [INT_BITS-1:0] pix_x;
	logic signed [INT_BITS-1:0] pix_y;

	// Keep a pixel inside 0 .. hi
	function automatic logic signed [INT_BITS-1:0] clamp_pix(
		input logic signed [INT_BITS-1:0] v,
		input int                         hi
	);
		if (v < 0)
			return '0;
		if (int'(v) > hi)
			return INT_BITS'(hi);
		return v;
	endfunction

	// Integer part only, fraction dropped
	assign pix_x = state.pos_x[FIX_W-1:FRAC_BITS];
	assign pix_y = state.pos_y[FIX_W-1:FRAC_BITS];

	always_ff @(posedge clock) begin
		if (reset) begin
			position_valid <= 1'b0;
			position.raw   <= '0;
		end else begin
			position_valid <= state.state_valid; // One pulse per frame
			if (state.state_valid) begin
				position.xy.x <= clamp_pix(pix_x, ARENA_W - 1);
				position.xy.y <= clamp_pix(pix_y, ARENA_H - 1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/physics_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module physics_top import physics_pkg::*; (
	input  wire                  clock,
	input  wire                  reset,
	// AXI4-Lite register port
	input  wire [AXI_ADDR_W-1:0] awaddr,
	input  wire                  awvalid,
	output wire                  awready,
	input  wire [DATA_W-1:0]     wdata,
	input  wire                  wvalid,
	output wire                  wready,
	output wire [1:0]            bresp,
	output wire                  bvalid,
	input  wire                  bready,
	input  wire [AXI_ADDR_W-1:0] araddr,
	input  wire                  arvalid,
	output wire                  arready,
	output wire [DATA_W-1:0]     rdata,
	output wire [1:0]            rresp,
	output wire                  rvalid,
	input  wire                  rready,
	// Frame inputs
	input  wire                  step,
	input  wire [31:0]           controller,
	input  wire [4:0]            wall,
	input  wire [31:0]           knockback,  // x high, y low
	input  wire                  attack_in,
	input  wire                  freeze_in,
	output wire [31:0]           position,
	output wire                  position_valid
);

	body_config_if cfg_bus ();
	motion_cmd_if  cmd_bus ();
	body_state_if  state_bus ();

	physics_regs u_regs (
		.clock        (clock),
		.reset        (reset),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.position_now (position),  // Readback of the registered result
		.cfg          (cfg_bus.source)
	);

	input_decode u_decode (
		.clock      (clock),
		.reset      (reset),
		.step       (step),
		.controller (controller),
		.wall       (wall),
		.knockback  (knockback),
		.attack_in  (attack_in),
		.freeze_in  (freeze_in),
		.cmd        (cmd_bus.source)
	);

	motion_integrator u_integrator (
		.clock (clock),
		.reset (reset),
		.cfg   (cfg_bus.sink),
		.cmd   (cmd_bus.sink),
		.state (state_bus.source)
	);

	position_result u_result (
		.clock          (clock),
		.reset          (reset),
		.state          (state_bus.sink),
		.position       (position),
		.position_valid (position_valid)
	);

endmodule

`default_nettype wire

// ==== verif/physics_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module physics_tb import physics_pkg::*; ();

	localparam int FALL_FRAMES   = 24;
	localparam int PLAY_FRAMES   = 400;
	localparam int ATTACK_FRAMES = 32;
	localparam int FREEZE_FRAMES = 12;
	localparam int TOTAL_FRAMES  = FALL_FRAMES + PLAY_FRAMES + ATTACK_FRAMES + FREEZE_FRAMES
		+ 10;

	logic                  clock;
	logic                  reset;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [DATA_W-1:0]     wdata;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [DATA_W-1:0]     rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic                  step;
	logic [31:0]           controller;
	logic [4:0]            wall;
	logic [31:0]           knockback;
	logic                  attack_in;
	logic                  freeze_in;
	logic [31:0]           position;
	logic                  position_valid;

	integer      seed = 32'hc7f8ebc7;
	coord_pair_u exp_q[$];      // One entry per step in flight
	time         due_q[$];      // When each frame's valid pulse is due
	coord_pair_u last_exp;
	int          frames_seen = 0;

	// Reference state in 16.32 fixed point
	fix_t m_mass = fix_t'(1);
	fix_t m_grav = '0;
	fix_t m_vx   = '0;
	fix_t m_vy   = '0;
	fix_t m_px   = '0;
	fix_t m_py   = '0;
	fix_t m_ref  = '0;
	logic m_atk  = 1'b0;

	physics_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic stop_run();
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_position(input string name, input coord_pair_u expected,
		input coord_pair_u actual);
		if (actual !== expected) begin
			$display("Fail %s: expected x=%0d y=%0d, actual x=%0d y=%0d", name,
				expected.xy.x, expected.xy.y, actual.xy.x, actual.xy.y);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %s, actual %s", name, expected.name(), actual.name());
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_latency(input string name, input time expected, input time actual);
		if (actual != expected) begin
			$display("Fail %s: expected valid at %0t, actual at %0t", name, expected, actual);
			stop_run();
		end
	endtask

	// Integer pixel held inside 0 .. hi
	function automatic logic signed [INT_BITS-1:0] clamp_pixel(input fix_t v, input int hi);
		int p;
		p = int'($signed(v[FIX_W-1:FRAC_BITS]));
		if (p < 0)
			p = 0;
		else if (p > hi)
			p = hi;
		return INT_BITS'(p);
	endfunction

	// One frame of the motion rules queues its expected pixels
	task automatic model_frame(input logic [31:0] ctrl, input logic [4:0] wl,
		input coord_pair_u kb, input logic atk, input logic frz);
		fix_t        mx;
		fix_t        my;
		logic        gnd;
		logic        jmp;
		coord_pair_u pix;
		mx  = fix_t'((int'(ctrl[15:8]) - JOY_CENTER) * JOY_SCALE);
		my  = fix_t'((int'(ctrl[7:0]) - JOY_CENTER) * JOY_SCALE);
		gnd = wl[1] | wl[4];              // Floor or platform
		jmp = int'(ctrl[7:0]) >= JUMP_MIN;
		if (!frz) begin
			if (atk && !m_atk) begin
				m_py  = m_py + LIFT;          // Rising attack
				m_ref = m_py;
			end else if (atk) begin
				m_vx = fix_t'(kb.xy.x) / m_mass;
				m_vy = fix_t'(kb.xy.y) / m_mass;
				m_py = (m_py < m_ref + VIBR_SPAN) ? m_py + VIBR_STEP : m_py - VIBR_STEP;
			end else begin
				m_px = m_px + m_vx;           // Old velocity moves the body
				if (!gnd)
					m_py = m_py + m_vy;
				m_vx = mx / m_mass;
				m_vy = jmp ? my / m_mass : (gnd ? fix_t'(0) : my / m_mass - m_grav);
			end
			m_atk = atk;
		end
		pix.xy.x = clamp_pixel(m_px, ARENA_W - 1);
		pix.xy.y = clamp_pixel(m_py, ARENA_H - 1);
		exp_q.push_back(pix);
		last_exp = pix;
	endtask

	task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		output resp_t resp);
		@(negedge clock);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clock);
		while (!(awready && wready))
			@(negedge clock);
		@(negedge clock);                 // Taken on the edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge clock);
		repeat ($random(seed) & 3) @(negedge clock); // B back-pressure
		resp   = resp_t'(bresp);
		bready = 1'b1;
		@(negedge clock);
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output resp_t resp);
		@(negedge clock);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clock);
		while (!arready)
			@(negedge clock);
		@(negedge clock);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clock);
		repeat ($random(seed) & 3) @(negedge clock); // R back-pressure
		data   = rdata;
		resp   = resp_t'(rresp);
		rready = 1'b1;
		@(negedge clock);
		rready = 1'b0;
	endtask

	task automatic send_frame(input logic [31:0] ctrl, input logic [4:0] wl,
		input logic [31:0] kb, input logic atk, input logic frz);
		@(negedge clock);
		step       = 1'b1;
		controller = ctrl;
		wall       = wl;
		knockback  = kb;
		attack_in  = atk;
		freeze_in  = frz;
		model_frame(ctrl, wl, kb, atk, frz);
		due_q.push_back($time + 3 * 10); // Decode, integrate, result
	endtask

	task automatic rest();
		@(negedge clock);
		step = 1'b0;
	endtask

	// Let every frame in flight come out
	task automatic drain();
		rest();
		while (exp_q.size() != 0)
			@(negedge clock);
		repeat (2) @(negedge clock);
	endtask

	task automatic move_to_spawn(input int x, input int y);
		coord_pair_u         sp;
		resp_t               r;
		logic [DATA_W-1:0]   d;
		sp.xy.x = INT_BITS'(x);
		sp.xy.y = INT_BITS'(y);
		write_reg(REG_SPAWN, sp.raw, r);
		check_resp("spawn write", OKAY, r);
		m_px  = fix_t'(sp.xy.x) <<< FRAC_BITS;
		m_py  = fix_t'(sp.xy.y) <<< FRAC_BITS;
		m_vx  = '0;                       // Body at rest
		m_vy  = '0;
		m_atk = 1'b0;
		read_reg(REG_SPAWN, d, r);
		check_position("spawn readback", sp, d);
	endtask

	// Every pulse pops the oldest expected frame
	always @(negedge clock) begin
		if (!reset && position_valid) begin
			if (exp_q.size() == 0) begin
				$display("position_valid pulsed with no frame outstanding");
				stop_run();
			end else begin
				check_position($sformatf("frame %0d", frames_seen), exp_q.pop_front(), position);
				check_latency($sformatf("frame %0d latency", frames_seen), due_q.pop_front(),
					$time);
				frames_seen++;
			end
		end
	end

	initial begin
		repeat (TOTAL_FRAMES * 20 + 2000) @(posedge clock);
		$display("Timeout: the run hung past %0d cycles", TOTAL_FRAMES * 20 + 2000);
		stop_run();
	end

	initial begin
		resp_t             r;
		logic [DATA_W-1:0] d;
		logic [31:0]       rnd;
		logic [31:0]       kb;
		int                n;
		reset      = 1'b1;
		{awaddr, awvalid, wdata, wvalid, bready} = '0;
		{araddr, arvalid, rready} = '0;
		{step, controller, wall, knockback, attack_in, freeze_in} = '0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// Register access
		write_reg(REG_MASS, '0, r);
		check_resp("mass zero write", OKAY, r);
		read_reg(REG_MASS, d, r);
		check_word("mass zero floor", 32'd1, d);
		rnd = ($random(seed) & 7) + 1;
		write_reg(REG_MASS, rnd, r);
		check_resp("mass write", OKAY, r);
		read_reg(REG_MASS, d, r);
		check_word("mass readback", rnd, d);
		m_mass = fix_t'(rnd);
		write_reg(REG_GRAVITY, 32'h4000_0000, r); // Quarter pixel per frame
		check_resp("gravity write", OKAY, r);
		read_reg(REG_GRAVITY, d, r);
		check_word("gravity readback", 32'h4000_0000, d);
		m_grav = fix_t'(32'h4000_0000);
		write_reg(4'h6, 32'hdead_beef, r);
		check_resp("unknown write", SLVERR, r);
		read_reg(4'h6, d, r);
		check_resp("unknown read", SLVERR, r);

		// Respawn and free fall with the stick centered
		move_to_spawn(100, 300);
		repeat (FALL_FRAMES) send_frame({16'h0, 8'd112, 8'd112}, 5'd0, 32'h0, 1'b0, 1'b0);
		drain();

		// Random play from past the right edge
		move_to_spawn(700, 30);
		n = 0;
		while (n < PLAY_FRAMES) begin
			rnd = $random(seed);
			kb  = $random(seed);
			if (rnd[2:0] == 3'd0) begin
				rest();                       // Gap between frames
			end else begin
				send_frame({16'h0, rnd[15:8], rnd[23:16]},
					{rnd[27] & rnd[28], rnd[3], rnd[4], rnd[30] & rnd[31], rnd[5]},
					kb, 1'b0, &rnd[26:24]);
				n++;
			end
		end
		drain();

		// Attack lift, vibration, then release
		write_reg(REG_GRAVITY, 32'd2, r); // One vibration step per frame
		check_resp("fine gravity write", OKAY, r);
		m_grav = fix_t'(32'd2);
		move_to_spawn(200, 100);
		// Two falling frames leave y just under a pixel boundary
		repeat (2) send_frame({16'h0, 8'd112, 8'd112}, 5'd0, 32'h0, 1'b0, 1'b0);
		kb = $random(seed);
		repeat (ATTACK_FRAMES) send_frame($random(seed), 5'd0, kb, 1'b1, 1'b0);
		repeat (4) send_frame({16'h0, 8'd112, 8'd112}, 5'd0, kb, 1'b0, 1'b0);
		drain();
		read_reg(REG_POSITION, d, r);
		check_resp("position read", OKAY, r);
		check_position("position readback", last_exp, d);

		// Frozen frames still strobe
		repeat (FREEZE_FRAMES) send_frame($random(seed), 5'd0, $random(seed), $random(seed), 1'b1);
		repeat (4) send_frame($random(seed), 5'd2, 32'h0, 1'b0, 1'b0);
		drain();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/physics_pkg.sv
source/physics_ifs.sv
source/physics_regs.sv
source/input_decode.sv
source/motion_integrator.sv
source/position_result.sv
source/physics_top.sv
verif/physics_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the physics testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module physics_tb -f tb.f -o physics_sim

./obj_dir/physics_sim 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
	echo "Run failed, see sim.log"
	exit 1
fi
echo "Run passed"
